//--- dispatch_macros.svh
`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// Data path and address width
`define DATA_W 32

// Architectural register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// Rename tags, one per in-flight result
`define TAG_W 6
`define NUM_TAGS 64

// Instruction fields that are wider than a register address
`define IMM_W 16
`define JADDR_W 26

`endif

//--- dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

   `include "dispatch_macros.svh"

   // Primary opcodes that dispatch understands
   typedef enum logic [5:0] {
      OPC_RTYPE = 6'h00,
      OPC_J     = 6'h02,
      OPC_BEQ   = 6'h04,
      OPC_BNE   = 6'h05,
      OPC_LW    = 6'h23,
      OPC_SW    = 6'h2b
   } opcode_e;

   // R-type functions that leave the integer queue
   typedef enum logic [5:0] {
      FN_MULT  = 6'h18,
      FN_MULTU = 6'h19,
      FN_DIV   = 6'h1a,
      FN_DIVU  = 6'h1b
   } funct_e;

   // Also the bit index into queue_vec_t
   typedef enum logic [1:0] {
      Q_INT  = 2'd0,
      Q_LS   = 2'd1,
      Q_MULT = 2'd2,
      Q_DIV  = 2'd3
   } queue_e;

   typedef enum logic {
      LS_LW = 1'b0,
      LS_SW = 1'b1
   } ls_op_e;

   typedef enum logic {
      ST_DISPATCH     = 1'b0,
      ST_BRANCH_STALL = 1'b1
   } dispatch_state_e;

   typedef struct packed {
      logic [`TAG_W-1:0]  tag;
      logic               valid;
      logic [`DATA_W-1:0] data;
      logic               branch;
      logic               branch_taken;
   } cdb_t;

   typedef logic [3:0] queue_vec_t;

   typedef struct packed {
      queue_e                 queue;
      logic [5:0]             int_opcode;
      ls_op_e                 ls_opcode;
      logic [`REG_ADDR_W-1:0] rs_addr;
      logic [`REG_ADDR_W-1:0] rt_addr;
      logic [`REG_ADDR_W-1:0] dest_addr;
      logic [`DATA_W-1:0]     imm;
      logic [`DATA_W-1:0]     branch_target;
      logic [`DATA_W-1:0]     jump_target;
      logic                   needs_queue;
      logic                   needs_tag;
      logic                   is_branch;
      logic                   is_jump;
      logic                   is_load;
   } decoded_inst_t;

   typedef struct packed {
      logic [`DATA_W-1:0] imm;
      logic [`TAG_W-1:0]  rd_tag;
      logic [`TAG_W-1:0]  rs_tag;
      logic [`TAG_W-1:0]  rt_tag;
      logic [`DATA_W-1:0] rs_data;
      logic [`DATA_W-1:0] rt_data;
      logic               rs_valid;
      logic               rt_valid;
   } queue_entry_t;

endpackage

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module inst_decoder (
   input  wire [`DATA_W-1:0]          inst,
   input  wire [`DATA_W-1:0]          pc_plus4,
   output dispatch_pkg::decoded_inst_t decoded
);

   import dispatch_pkg::*;

   opcode_e opcode;
   funct_e  funct;

   assign opcode = opcode_e'(inst[31:26]);
   assign funct  = funct_e'(inst[5:0]);

   always_comb begin
      decoded.rs_addr = inst[25:21];
      decoded.rt_addr = inst[20:16];
      decoded.imm     = {{(`DATA_W-`IMM_W){inst[`IMM_W-1]}}, inst[`IMM_W-1:0]};

      // Both targets are word addresses shifted into byte addresses
      decoded.branch_target = pc_plus4 + {decoded.imm[`DATA_W-3:0], 2'b00};
      decoded.jump_target   = {pc_plus4[`DATA_W-1:`JADDR_W+2], inst[`JADDR_W-1:0], 2'b00};

      // Anything not recognised below has no queue and is not a jump
      decoded.queue       = Q_INT;
      decoded.int_opcode  = 6'h00;
      decoded.ls_opcode   = LS_LW;
      decoded.needs_queue = 1'b0;
      decoded.needs_tag   = 1'b0;
      decoded.is_branch   = 1'b0;
      decoded.is_jump     = 1'b0;
      decoded.is_load     = 1'b0;

      case (opcode)
         OPC_RTYPE: begin
            decoded.needs_queue = 1'b1;
            decoded.needs_tag   = 1'b1;
            case (funct)
               FN_MULT, FN_MULTU: decoded.queue = Q_MULT;
               FN_DIV, FN_DIVU:   decoded.queue = Q_DIV;
               default:           decoded.int_opcode = inst[5:0];
            endcase
         end
         OPC_BEQ, OPC_BNE: begin
            // The integer unit evaluates the compare, so it sees the opcode
            decoded.int_opcode  = inst[31:26];
            decoded.needs_queue = 1'b1;
            decoded.is_branch   = 1'b1;
         end
         OPC_J: decoded.is_jump = 1'b1;
         OPC_LW: begin
            decoded.queue       = Q_LS;
            decoded.ls_opcode   = LS_LW;
            decoded.needs_queue = 1'b1;
            decoded.needs_tag   = 1'b1;
            decoded.is_load     = 1'b1;
         end
         OPC_SW: begin
            decoded.queue       = Q_LS;
            decoded.ls_opcode   = LS_SW;
            decoded.needs_queue = 1'b1;
         end
         default: ;
      endcase

      // Loads write rt, every other producer writes rd
      decoded.dest_addr = decoded.is_load ? inst[20:16] : inst[15:11];
   end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module register_file (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire [`NUM_REGS-1:0]     wen_onehot,
   input  wire [`DATA_W-1:0]       wdata,
   input  wire [`REG_ADDR_W-1:0]   rs_addr,
   input  wire [`REG_ADDR_W-1:0]   rt_addr,
   output logic [`DATA_W-1:0]      rs_data,
   output logic [`DATA_W-1:0]      rt_data
);

   logic [`DATA_W-1:0] regs [`NUM_REGS];

   // The status table decides which register the CDB result belongs to
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
      end else begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (wen_onehot[i]) regs[i] <= wdata;
         end
      end
   end

   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

   // Tags are unique in flight, so one CDB result matches at most one register
   a_wen_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(wen_onehot))
      else $error("register_file: CDB result written to several registers");

endmodule

`default_nettype wire

//--- register_status_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module register_status_table (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire [`REG_ADDR_W-1:0] rs_addr,
   input  wire [`REG_ADDR_W-1:0] rt_addr,
   output logic [`TAG_W-1:0]     rs_tag,
   output logic [`TAG_W-1:0]     rt_tag,
   output logic                  rs_busy,
   output logic                  rt_busy,
   input  wire                   alloc,
   input  wire [`REG_ADDR_W-1:0] alloc_addr,
   input  wire [`TAG_W-1:0]      alloc_tag,
   input  wire dispatch_pkg::cdb_t cdb,
   output logic [`NUM_REGS-1:0]  wen_onehot
);

   import dispatch_pkg::*;

   logic [`NUM_REGS-1:0] busy;
   logic [`TAG_W-1:0]    tags [`NUM_REGS];

   assign rs_tag  = tags[rs_addr];
   assign rt_tag  = tags[rt_addr];
   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];

   // A register waiting on the published tag takes the CDB value
   always_comb begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         wen_onehot[i] = cdb.valid && busy[i] && (tags[i] == cdb.tag);
      end
   end

   // A new producer replaces the pending one even if that one completes now
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= '0;
      end else begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (alloc && (alloc_addr == `REG_ADDR_W'(i))) begin
               busy[i] <= 1'b1;
            end else if (wen_onehot[i]) begin
               busy[i] <= 1'b0;
            end
         end
      end
   end

   // Producing tag of each register, written when its destination is renamed
   always_ff @(posedge clk) begin
      if (alloc) tags[alloc_addr] <= alloc_tag;
   end

endmodule

`default_nettype wire

//--- tag_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module tag_fifo (
   input  wire                    clk,
   input  wire                    arst_n,
   input  wire                    pop,
   input  wire dispatch_pkg::cdb_t cdb,
   output logic [`TAG_W-1:0]      free_tag,
   output logic                   tag_empty
);

   import dispatch_pkg::*;

   // Pointers are TAG_W wide and wrap by themselves over NUM_TAGS slots
   logic [`TAG_W-1:0] mem [`NUM_TAGS];
   logic [`TAG_W-1:0] rd_ptr;
   logic [`TAG_W-1:0] wr_ptr;
   logic [`TAG_W:0]   count;
   logic              push;
   logic              full;

   assign push      = cdb.valid;
   assign full      = (count == (`TAG_W+1)'(`NUM_TAGS));
   assign tag_empty = (count == '0);
   assign free_tag  = mem[rd_ptr];

   // Every tag starts out free, in ascending order
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `NUM_TAGS; i++) mem[i] <= `TAG_W'(i);
      end else if (push) begin
         mem[wr_ptr] <= cdb.tag;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (`TAG_W+1)'(`NUM_TAGS);
      end else begin
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (push) wr_ptr <= wr_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // A returning tag must have been handed out earlier
   a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
      !(push && full))
      else $error("tag_fifo: CDB returned a tag that was never allocated");

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      !(pop && tag_empty))
      else $error("tag_fifo: dispatch consumed a tag with none free");

endmodule

`default_nettype wire

//--- operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module operand_fetch (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire dispatch_pkg::decoded_inst_t decoded,
   input  wire dispatch_pkg::cdb_t      cdb,
   input  wire [`TAG_W-1:0]             free_tag,
   input  wire                          dispatch_fire,
   output dispatch_pkg::queue_entry_t   queue_entry
);

   import dispatch_pkg::*;

   logic [`DATA_W-1:0]   rf_rs_data;
   logic [`DATA_W-1:0]   rf_rt_data;
   logic [`TAG_W-1:0]    rs_tag;
   logic [`TAG_W-1:0]    rt_tag;
   logic                 rs_busy;
   logic                 rt_busy;
   logic [`NUM_REGS-1:0] wen_onehot;
   logic                 rs_fwd;
   logic                 rt_fwd;

   register_file u_register_file (
      .clk        (clk),
      .arst_n     (arst_n),
      .wen_onehot (wen_onehot),
      .wdata      (cdb.data),
      .rs_addr    (decoded.rs_addr),
      .rt_addr    (decoded.rt_addr),
      .rs_data    (rf_rs_data),
      .rt_data    (rf_rt_data)
   );

   register_status_table u_register_status_table (
      .clk        (clk),
      .arst_n     (arst_n),
      .rs_addr    (decoded.rs_addr),
      .rt_addr    (decoded.rt_addr),
      .rs_tag     (rs_tag),
      .rt_tag     (rt_tag),
      .rs_busy    (rs_busy),
      .rt_busy    (rt_busy),
      .alloc      (dispatch_fire),
      .alloc_addr (decoded.dest_addr),
      .alloc_tag  (free_tag),
      .cdb        (cdb),
      .wen_onehot (wen_onehot)
   );

   // The register file only sees this result at the next edge
   assign rs_fwd = rs_busy && cdb.valid && (cdb.tag == rs_tag);
   assign rt_fwd = rt_busy && cdb.valid && (cdb.tag == rt_tag);

   always_comb begin
      queue_entry.imm      = decoded.imm;
      queue_entry.rd_tag   = free_tag;
      queue_entry.rs_tag   = rs_tag;
      queue_entry.rs_data  = rs_fwd ? cdb.data : rf_rs_data;
      queue_entry.rs_valid = !rs_busy || rs_fwd;
      queue_entry.rt_data  = rt_fwd ? cdb.data : rf_rt_data;
      // rt of a load is its destination, so it carries the new tag
      if (decoded.is_load) begin
         queue_entry.rt_tag   = free_tag;
         queue_entry.rt_valid = 1'b1;
      end else begin
         queue_entry.rt_tag   = rt_tag;
         queue_entry.rt_valid = !rt_busy || rt_fwd;
      end
   end

endmodule

`default_nettype wire

//--- issue_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module issue_control (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire dispatch_pkg::decoded_inst_t decoded,
   input  wire                          ifq_empty,
   input  wire                          tag_empty,
   input  wire dispatch_pkg::queue_vec_t queue_ready,
   input  wire dispatch_pkg::cdb_t      cdb,
   output dispatch_pkg::queue_vec_t     queue_en,
   output logic                         ifq_ren,
   output logic                         dispatch_fire,
   output logic                         ifq_redirect,
   output logic [`DATA_W-1:0]           ifq_redirect_addr
);

   import dispatch_pkg::*;

   dispatch_state_e    state;
   dispatch_state_e    state_next;
   logic [`DATA_W-1:0] saved_target;
   logic               head_valid;
   logic               open;
   logic               taken;
   logic               go;
   logic               discard;

   assign head_valid = !ifq_empty;
   assign taken      = (state == ST_BRANCH_STALL) && cdb.branch && cdb.branch_taken;

   // The head may proceed when no branch is pending or the pending one fell through
   assign open = (state == ST_DISPATCH) || (cdb.branch && !cdb.branch_taken);

   assign go = open && head_valid && decoded.needs_queue
      && queue_ready[decoded.queue] && (!decoded.needs_tag || !tag_empty);

   // Unknown opcodes are dropped so that dispatch keeps moving
   assign discard = open && head_valid && !decoded.needs_queue && !decoded.is_jump;

   always_comb begin
      queue_en                 = '0;
      queue_en[decoded.queue]  = go;
      ifq_ren                  = go || discard;
      dispatch_fire            = go && decoded.needs_tag;
      ifq_redirect             = taken || (open && head_valid && decoded.is_jump);
      ifq_redirect_addr        = taken ? saved_target : decoded.jump_target;

      state_next = state;
      if (go && decoded.is_branch) begin
         state_next = ST_BRANCH_STALL;
      end else if (state == ST_BRANCH_STALL && cdb.branch) begin
         state_next = ST_DISPATCH;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_DISPATCH;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (go && decoded.is_branch) saved_target <= decoded.branch_target;
   end

   a_queue_en_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(queue_en))
      else $error("issue_control: more than one queue enabled");

endmodule

`default_nettype wire

//--- dispatch_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module dispatch_top (
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire [`DATA_W-1:0]            ifq_inst,
   input  wire [`DATA_W-1:0]            ifq_pc_plus4,
   input  wire                          ifq_empty,
   output logic                         ifq_ren,
   output logic                         ifq_redirect,
   output logic [`DATA_W-1:0]           ifq_redirect_addr,
   input  wire dispatch_pkg::cdb_t      cdb,
   input  wire dispatch_pkg::queue_vec_t queue_ready,
   output dispatch_pkg::queue_vec_t     queue_en,
   output logic [5:0]                   int_opcode,
   output dispatch_pkg::ls_op_e         ls_opcode,
   output dispatch_pkg::queue_entry_t   queue_entry
);

   import dispatch_pkg::*;

   decoded_inst_t     decoded;
   logic [`TAG_W-1:0] free_tag;
   logic              tag_empty;
   logic              dispatch_fire;

   assign int_opcode = decoded.int_opcode;
   assign ls_opcode  = decoded.ls_opcode;

   inst_decoder u_inst_decoder (
      .inst     (ifq_inst),
      .pc_plus4 (ifq_pc_plus4),
      .decoded  (decoded)
   );

   // Only a dispatched tag consumer takes a tag from the free list
   tag_fifo u_tag_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .pop       (dispatch_fire),
      .cdb       (cdb),
      .free_tag  (free_tag),
      .tag_empty (tag_empty)
   );

   operand_fetch u_operand_fetch (
      .clk           (clk),
      .arst_n        (arst_n),
      .decoded       (decoded),
      .cdb           (cdb),
      .free_tag      (free_tag),
      .dispatch_fire (dispatch_fire),
      .queue_entry   (queue_entry)
   );

   issue_control u_issue_control (
      .clk               (clk),
      .arst_n            (arst_n),
      .decoded           (decoded),
      .ifq_empty         (ifq_empty),
      .tag_empty         (tag_empty),
      .queue_ready       (queue_ready),
      .cdb               (cdb),
      .queue_en          (queue_en),
      .ifq_ren           (ifq_ren),
      .dispatch_fire     (dispatch_fire),
      .ifq_redirect      (ifq_redirect),
      .ifq_redirect_addr (ifq_redirect_addr)
   );

endmodule

`default_nettype wire

//--- tb_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_macros.svh"

module tb_dispatch;

   import dispatch_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int NUM_CYCLES = 400;
   localparam int MAX_WAIT   = 20;

   typedef struct packed {
      queue_vec_t             en;
      logic                   ren;
      logic                   fire;
      logic                   redir;
      logic [`DATA_W-1:0]     raddr;
      logic                   go;
      logic                   is_branch;
      logic                   is_load;
      logic [5:0]             int_op;
      logic                   ls_op;
      logic [`DATA_W-1:0]     btarget;
      logic [`REG_ADDR_W-1:0] dest;
      queue_entry_t           qe;
   } expect_t;

   logic               clk;
   logic               arst_n;
   logic [`DATA_W-1:0] ifq_inst;
   logic [`DATA_W-1:0] ifq_pc_plus4;
   logic               ifq_empty;
   logic               ifq_ren;
   logic               ifq_redirect;
   logic [`DATA_W-1:0] ifq_redirect_addr;
   cdb_t               cdb;
   queue_vec_t         queue_ready;
   queue_vec_t         queue_en;
   logic [5:0]         int_opcode;
   ls_op_e             ls_opcode;
   queue_entry_t       queue_entry;

   // Reference state of the rename logic
   logic               m_busy [`NUM_REGS];
   logic [`TAG_W-1:0]  m_tag  [`NUM_REGS];
   logic [`DATA_W-1:0] m_val  [`NUM_REGS];
   logic [`TAG_W-1:0]  m_fifo [`NUM_TAGS];
   logic [`TAG_W-1:0]  m_rd;
   logic [`TAG_W-1:0]  m_wr;
   int                 m_cnt;
   logic               m_stall;
   logic [`DATA_W-1:0] m_saved;
   int                 seed;

   dispatch_top UUT (
      .clk               (clk),
      .arst_n            (arst_n),
      .ifq_inst          (ifq_inst),
      .ifq_pc_plus4      (ifq_pc_plus4),
      .ifq_empty         (ifq_empty),
      .ifq_ren           (ifq_ren),
      .ifq_redirect      (ifq_redirect),
      .ifq_redirect_addr (ifq_redirect_addr),
      .cdb               (cdb),
      .queue_ready       (queue_ready),
      .queue_en          (queue_en),
      .int_opcode        (int_opcode),
      .ls_opcode         (ls_opcode),
      .queue_entry       (queue_entry)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic compare(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      if (actual !== expected) begin
         $display("error: %s is %h, expected %h", name, actual, expected);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                         input logic [5:0] fn);
      return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                         input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   // Expected outputs from the decode and rename rules and the current model state
   function automatic expect_t reference();
      expect_t            e;
      logic [5:0]         op;
      logic [5:0]         fn;
      logic [4:0]         rs;
      logic [4:0]         rt;
      logic [1:0]         q;
      logic               needq;
      logic               needtag;
      logic               jmp;
      logic               open;
      logic               taken;
      logic               disc;
      logic               rs_fwd;
      logic               rt_fwd;
      logic [`DATA_W-1:0] imm;
      e       = '0;
      op      = ifq_inst[31:26];
      fn      = ifq_inst[5:0];
      rs      = ifq_inst[25:21];
      rt      = ifq_inst[20:16];
      imm     = {{16{ifq_inst[15]}}, ifq_inst[15:0]};
      q       = 2'd0;
      needq   = 1'b0;
      needtag = 1'b0;
      jmp     = 1'b0;
      case (op)
         6'h00: begin
            needq   = 1'b1;
            needtag = 1'b1;
            if (fn == 6'h18 || fn == 6'h19) q = 2'd2;
            else if (fn == 6'h1a || fn == 6'h1b) q = 2'd3;
            else e.int_op = fn;
         end
         6'h04, 6'h05: begin
            needq       = 1'b1;
            e.is_branch = 1'b1;
            e.int_op    = op;
         end
         6'h02: jmp = 1'b1;
         6'h23: begin
            q         = 2'd1;
            needq     = 1'b1;
            needtag   = 1'b1;
            e.is_load = 1'b1;
         end
         6'h2b: begin
            q       = 2'd1;
            needq   = 1'b1;
            e.ls_op = 1'b1;
         end
         default: ;
      endcase
      e.dest    = e.is_load ? rt : ifq_inst[15:11];
      e.btarget = ifq_pc_plus4 + (imm << 2);
      open  = !m_stall || (cdb.branch && !cdb.branch_taken);
      taken = m_stall && cdb.branch && cdb.branch_taken;
      e.go  = open && !ifq_empty && needq && queue_ready[q] && (!needtag || m_cnt != 0);
      disc  = open && !ifq_empty && !needq && !jmp;
      e.en[q]  = e.go;
      e.ren    = e.go || disc;
      e.fire   = e.go && needtag;
      e.redir  = taken || (open && !ifq_empty && jmp);
      e.raddr  = taken ? m_saved
                       : {ifq_pc_plus4[31:28], ifq_inst[25:0], 2'b00};
      rs_fwd = m_busy[rs] && cdb.valid && cdb.tag == m_tag[rs];
      rt_fwd = m_busy[rt] && cdb.valid && cdb.tag == m_tag[rt];
      e.qe.imm      = imm;
      e.qe.rd_tag   = m_fifo[m_rd];
      e.qe.rs_tag   = m_tag[rs];
      e.qe.rs_data  = rs_fwd ? cdb.data : m_val[rs];
      e.qe.rs_valid = !m_busy[rs] || rs_fwd;
      e.qe.rt_data  = rt_fwd ? cdb.data : m_val[rt];
      e.qe.rt_tag   = e.is_load ? m_fifo[m_rd] : m_tag[rt];
      e.qe.rt_valid = e.is_load || !m_busy[rt] || rt_fwd;
      return e;
   endfunction

   task automatic check_outputs(input expect_t e);
      compare("queue_en", 32'(queue_en), 32'(e.en));
      compare("ifq_ren", 32'(ifq_ren), 32'(e.ren));
      compare("ifq_redirect", 32'(ifq_redirect), 32'(e.redir));
      if (e.redir) compare("ifq_redirect_addr", ifq_redirect_addr, e.raddr);
      if (e.go) begin
         compare("queue_entry.imm", queue_entry.imm, e.qe.imm);
         compare("queue_entry.rd_tag", 32'(queue_entry.rd_tag), 32'(e.qe.rd_tag));
         compare("queue_entry.rs_valid", 32'(queue_entry.rs_valid), 32'(e.qe.rs_valid));
         compare("queue_entry.rt_valid", 32'(queue_entry.rt_valid), 32'(e.qe.rt_valid));
         if (e.qe.rs_valid) compare("queue_entry.rs_data", queue_entry.rs_data, e.qe.rs_data);
         else compare("queue_entry.rs_tag", 32'(queue_entry.rs_tag), 32'(e.qe.rs_tag));
         if (e.qe.rt_valid) compare("queue_entry.rt_data", queue_entry.rt_data, e.qe.rt_data);
         if (!e.qe.rt_valid || e.is_load)
            compare("queue_entry.rt_tag", 32'(queue_entry.rt_tag), 32'(e.qe.rt_tag));
         if (e.en[Q_INT]) compare("int_opcode", 32'(int_opcode), 32'(e.int_op));
         if (e.en[Q_LS]) compare("ls_opcode", 32'(ls_opcode), 32'(e.ls_op));
      end
   endtask

   // Applies what the coming rising edge does to the model
   task automatic update_model(input expect_t e);
      logic [`TAG_W-1:0] free;
      logic              wen;
      free = m_fifo[m_rd];
      for (int i = 0; i < `NUM_REGS; i++) begin
         wen = cdb.valid && m_busy[i] && m_tag[i] == cdb.tag;
         if (wen) m_val[i] = cdb.data;
         if (e.fire && e.dest == i) begin
            m_busy[i] = 1'b1;
            m_tag[i]  = free;
         end else if (wen) begin
            m_busy[i] = 1'b0;
         end
      end
      if (cdb.valid) begin
         m_fifo[m_wr] = cdb.tag;
         m_wr++;
         m_cnt++;
      end
      if (e.fire) begin
         m_rd++;
         m_cnt--;
      end
      if (e.go && e.is_branch) begin
         m_stall = 1'b1;
         m_saved = e.btarget;
      end else if (m_stall && cdb.branch) begin
         m_stall = 1'b0;
      end
   endtask

   // Samples one nanosecond before each rising edge, after the inputs have settled
   initial begin
      expect_t e;
      forever begin
         @(negedge clk);
         #(CLK_PERIOD/2 - 1);
         if (arst_n) begin
            e = reference();
            check_outputs(e);
            update_model(e);
         end
      end
   end

   initial begin
      #(NUM_CYCLES * CLK_PERIOD + 100);
      $display("timeout: the test sequence did not finish in time");
      $display("Simulation FAILED");
      $fatal(1);
   end

   task automatic drive(input logic [31:0] inst, input logic empty, input queue_vec_t ready,
                        input cdb_t bus);
      @(negedge clk);
      ifq_inst     = inst;
      ifq_pc_plus4 = 32'h0000_1000 + 32'($random(seed) & 32'h0000_0ffc);
      ifq_empty    = empty;
      queue_ready  = ready;
      cdb          = bus;
   endtask

   // Holds the instruction at the head until dispatch reads it
   task automatic issue(input logic [31:0] inst, input cdb_t bus);
      int waited;
      waited = 0;
      drive(inst, 1'b0, 4'hf, bus);
      #(CLK_PERIOD/2 - 2);
      while (!ifq_ren) begin
         waited++;
         if (waited > MAX_WAIT) begin
            $display("timeout: instruction %h was never read from the queue", inst);
            $display("Simulation FAILED");
            $fatal(1);
         end
         drive(inst, 1'b0, 4'hf, '0);
         #(CLK_PERIOD/2 - 2);
      end
      // The model has taken in this dispatch once the edge has passed
      @(posedge clk);
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) drive(32'h0, 1'b1, 4'hf, '0);
   endtask

   initial begin
      cdb_t bus;
      seed         = 31018;
      arst_n       = 1'b0;
      ifq_inst     = '0;
      ifq_pc_plus4 = '0;
      ifq_empty    = 1'b1;
      queue_ready  = '0;
      cdb          = '0;
      m_rd         = '0;
      m_wr         = '0;
      m_cnt        = `NUM_TAGS;
      m_stall      = 1'b0;
      m_saved      = '0;
      for (int i = 0; i < `NUM_REGS; i++) begin
         m_busy[i] = 1'b0;
         m_tag[i]  = '0;
         m_val[i]  = '0;
      end
      for (int i = 0; i < `NUM_TAGS; i++) m_fifo[i] = `TAG_W'(i);
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      idle(2);

      // Tags 0 to 3 go to r3, r0, r0 and r5 while every queue is routed
      issue(rtype(1, 2, 3, 6'h20), '0);
      issue(rtype(1, 2, 0, 6'h18), '0);
      issue(rtype(4, 2, 0, 6'h1b), '0);
      issue(itype(6'h23, 1, 5, 16'($random(seed))), '0);
      issue(itype(6'h2b, 2, 6, 16'hfffc), '0);
      issue(32'hfc00_0000, '0);
      // r7 depends on the pending r3 and r5
      issue(rtype(3, 5, 7, 6'h22), '0);

      // Tag 0 is published while r3 is being read
      bus       = '0;
      bus.valid = 1'b1;
      bus.tag   = 6'd0;
      bus.data  = $random(seed);
      issue(rtype(3, 1, 8, 6'h21), bus);
      issue(rtype(3, 3, 9, 6'h25), '0);

      // Back-pressure on the integer queue
      repeat (3) drive(rtype(9, 3, 10, 6'h20), 1'b0, 4'b1110, '0);
      issue(rtype(9, 3, 10, 6'h20), '0);

      // Jump, then a taken BNE
      drive({6'h02, 26'($random(seed))}, 1'b0, 4'hf, '0);
      issue(itype(6'h05, 1, 2, 16'($random(seed))), '0);
      drive(rtype(1, 2, 11, 6'h20), 1'b0, 4'hf, '0);
      bus        = '0;
      bus.branch = 1'b1;
      bus.branch_taken = 1'b1;
      drive(rtype(1, 2, 11, 6'h20), 1'b0, 4'hf, bus);

      // BEQ that falls through releases the waiting instruction
      issue(itype(6'h04, 3, 4, 16'h0010), '0);
      repeat (3) drive(rtype(1, 2, 12, 6'h20), 1'b0, 4'hf, '0);
      bus        = '0;
      bus.branch = 1'b1;
      issue(rtype(1, 2, 12, 6'h20), bus);

      // Use up every free tag, then show that dispatch stalls
      while (m_cnt > 0) issue(rtype(1, 2, 13 + ($random(seed) & 7), 6'h20), '0);
      repeat (3) drive(rtype(1, 2, 20, 6'h20), 1'b0, 4'hf, '0);
      bus       = '0;
      bus.valid = 1'b1;
      bus.tag   = m_tag[20 - 7];
      bus.data  = $random(seed);
      drive(rtype(1, 2, 20, 6'h20), 1'b0, 4'hf, bus);
      issue(rtype(1, 2, 20, 6'h20), '0);
      idle(3);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
dispatch_pkg.sv
inst_decoder.sv
register_file.sv
register_status_table.sv
tag_fifo.sv
operand_fetch.sv
issue_control.sv
dispatch_top.sv
tb_dispatch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the dispatch testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_dispatch \
   -o tb_dispatch_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_dispatch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ] || ! grep -q "^Simulation PASSED$" "$LOG"; then
   exit 1
fi
exit 0
